//--- files.f
+incdir+source
source/rvv_disp_pkg.sv
source/opr_byte_type.sv
source/dispatch_csr.sv
source/dispatch_pipe.sv
source/rvv_dispatch_top.sv
bench/tb_rvv_dispatch.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator and run it
# the simulator exit status carries pass or fail

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rvv_dispatch -f files.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed"
    exit $status
fi

./obj_dir/Vtb_rvv_dispatch
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed"
    exit $status
fi

exit 0

//--- bench/tb_rvv_dispatch.sv
// ------------------------------
// self-checking testbench for the dispatch slice
// reference model, LFSR stimulus, stall and latency checks
// ------------------------------
`timescale 1ns/1ps
`include "rvv_disp_defs.svh"

module tb_rvv_dispatch;
    localparam int NUM_UOPS   = 137;
    localparam int TIMEOUT_NS = (NUM_UOPS * 20 + 200) * 10;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    rvv_disp_pkg::exe_unit_e      exe_unit;
    rvv_disp_pkg::eew_e           vs1_eew;
    rvv_disp_pkg::eew_e           vs2_eew;
    rvv_disp_pkg::eew_e           vd_eew;
    rvv_disp_pkg::uop_index_t     uop_index;
    logic                         vm;
    logic                         ignore_vta;
    logic                         ignore_vma;
    logic                         out_valid;
    logic                         out_ready;
    rvv_disp_pkg::byte_type_vec_t vs2_byte_type;
    rvv_disp_pkg::byte_type_vec_t vd_byte_type;
    rvv_disp_pkg::byte_strobe_t   v0_strobe;
    logic                         csr_we;
    rvv_disp_pkg::vl_t            vl_wdata;
    rvv_disp_pkg::vstart_t        vstart_wdata;
    rvv_disp_pkg::v0_t            v0_wdata;

    // shadow of the last configuration written
    int          cfg_vl;
    int          cfg_vstart;
    logic [127:0] cfg_v0;

    logic [15:0]  lfsr;
    logic [15:0]  stall_lfsr;
    logic         stall_en;
    int           cycle;
    int           in_flight;
    logic [79:0]  exp_q[$];
    int           acc_q[$];
    logic [79:0]  got;
    logic [79:0]  want;
    int           acc_cycle;
    logic         held;
    logic [79:0]  held_val;

    rvv_dispatch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired: the micro-ops did not all complete in time");
        $display("STATUS: FAIL");
        $fatal(1);
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic rand_bits(input int n, output logic [127:0] r);
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            r    = {r[126:0], lfsr[0]};
        end
    endtask

    function automatic int elem_bytes(input rvv_disp_pkg::eew_e e);
        if (e == rvv_disp_pkg::EEW16)
            return 2;
        if (e == rvv_disp_pkg::EEW32)
            return 4;
        return 1;
    endfunction

    function automatic rvv_disp_pkg::eew_e eew_of(input int sel);
        if (sel == 1)
            return rvv_disp_pkg::EEW16;
        if (sel == 2)
            return rvv_disp_pkg::EEW32;
        return rvv_disp_pkg::EEW8;
    endfunction

    // expected result packed as vs2 types, vd types and strobe
    function automatic logic [79:0] expected_result(input rvv_disp_pkg::exe_unit_e exe,
            input rvv_disp_pkg::eew_e e1, input rvv_disp_pkg::eew_e e2,
            input rvv_disp_pkg::eew_e ed, input int idx,
            input logic v, input logic ta, input logic ma);
        int s1;
        int s2;
        int sd;
        int w;
        int s2_start;
        int v0_start;
        int win_lo;
        int win_hi;
        int ele;
        logic act;
        rvv_disp_pkg::byte_type_e bt;
        logic [31:0] t2;
        logic [31:0] td;
        logic [15:0] stb;
        s1 = elem_bytes(e1);
        s2 = elem_bytes(e2);
        sd = elem_bytes(ed);
        w  = (s2 > sd) ? s2 : sd;
        if (s1 > w)
            w = s1;
        t2 = '0;
        td = '0;
        stb = '0;
        // reduction takes the index in full and widening halves or quarters it
        if (exe == rvv_disp_pkg::RDT)
            s2_start = idx * (16 / s2);
        else
            s2_start = (idx / (w / s2)) * (16 / s2);
        v0_start = (idx / (w / sd)) * (16 / sd);
        win_lo   = v0_start + (idx % (w / sd)) * (16 / w);
        win_hi   = win_lo + 16 / w - 1;
        for (int i = 0; i < `VLENB; i++) begin
            ele = s2_start + i / s2;
            act = v || cfg_v0[ele] || ma;
            if (ta && ma)
                bt = rvv_disp_pkg::BODY_ACTIVE;
            else if (ele >= cfg_vl)
                bt = rvv_disp_pkg::TAIL;
            else if (ele < cfg_vstart)
                bt = rvv_disp_pkg::NOT_CHANGE;
            else
                bt = act ? rvv_disp_pkg::BODY_ACTIVE : rvv_disp_pkg::BODY_INACTIVE;
            t2[2*i +: 2] = bt;
            ele = v0_start + i / sd;
            act = v || cfg_v0[ele] || ma;
            if (exe == rvv_disp_pkg::RDT)
                bt = (i < sd) ? rvv_disp_pkg::BODY_ACTIVE : rvv_disp_pkg::TAIL;
            else if (ta && ma)
                bt = rvv_disp_pkg::BODY_ACTIVE;
            else if (ele >= cfg_vl)
                bt = rvv_disp_pkg::TAIL;
            else if (ele < cfg_vstart || ele < win_lo)
                bt = rvv_disp_pkg::NOT_CHANGE;
            else if (ele > win_hi)
                bt = rvv_disp_pkg::BODY_INACTIVE;
            else begin
                bt     = act ? rvv_disp_pkg::BODY_ACTIVE : rvv_disp_pkg::BODY_INACTIVE;
                stb[i] = act;
            end
            td[2*i +: 2] = bt;
        end
        return {t2, td, stb};
    endfunction

    task automatic report_error(input string msg);
        $display("error %0t: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (stall_en) begin
            stall_lfsr = lfsr_next(stall_lfsr);
            out_ready <= stall_lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    // record expected results at each accept edge
    always @(posedge clk) begin
        if (rst_n && in_valid && in_ready) begin
            exp_q.push_back(expected_result(exe_unit, vs1_eew, vs2_eew, vd_eew,
                                            int'(uop_index), vm, ignore_vta, ignore_vma));
            acc_q.push_back(stall_en ? -1 : cycle);
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            // stage one blocks only with both stages full and the output stalled
            assert (in_ready == (in_flight < 2 || out_ready))
            else report_error($sformatf("in_ready %b with %0d micro-ops in flight",
                                        in_ready, in_flight));
            if (held)
                assert (out_valid && {vs2_byte_type, vd_byte_type, v0_strobe} == held_val)
                else report_error("output changed while stalled");
            if (out_valid && out_ready) begin
                assert (exp_q.size() != 0)
                else report_error("result delivered with no micro-op outstanding");
                got       = {vs2_byte_type, vd_byte_type, v0_strobe};
                want      = exp_q.pop_front();
                acc_cycle = acc_q.pop_front();
                assert (got == want)
                else report_error($sformatf("result %h, expected %h", got, want));
                if (acc_cycle >= 0)
                    assert (cycle == acc_cycle + 2)
                    else report_error($sformatf("latency %0d cycles", cycle - acc_cycle));
            end
            held      <= out_valid && !out_ready;
            held_val  <= {vs2_byte_type, vd_byte_type, v0_strobe};
            in_flight <= in_flight + int'(in_valid && in_ready) - int'(out_valid && out_ready);
        end
    end

    task automatic write_cfg(input int new_vl, input int new_vstart, input logic [127:0] new_v0);
        csr_we       <= 1'b1;
        vl_wdata     <= rvv_disp_pkg::vl_t'(new_vl);
        vstart_wdata <= rvv_disp_pkg::vstart_t'(new_vstart);
        v0_wdata     <= new_v0;
        @(posedge clk);
        csr_we     <= 1'b0;
        cfg_vl     = new_vl;
        cfg_vstart = new_vstart;
        cfg_v0     = new_v0;
    endtask

    task automatic send(input rvv_disp_pkg::exe_unit_e exe, input rvv_disp_pkg::eew_e e1,
            input rvv_disp_pkg::eew_e e2, input rvv_disp_pkg::eew_e ed, input int idx,
            input logic v, input logic ta, input logic ma);
        in_valid   <= 1'b1;
        exe_unit   <= exe;
        vs1_eew    <= e1;
        vs2_eew    <= e2;
        vd_eew     <= ed;
        uop_index  <= rvv_disp_pkg::uop_index_t'(idx);
        vm         <= v;
        ignore_vta <= ta;
        ignore_vma <= ma;
        @(posedge clk);
        while (!in_ready)
            @(posedge clk);
    endtask

    task automatic drain();
        in_valid <= 1'b0;
        @(posedge clk);
        while (exp_q.size() != 0 || out_valid)
            @(posedge clk);
    endtask

    initial begin
        logic [127:0] r;
        logic [127:0] rv;
        rst_n = 1'b0;
        in_valid = 1'b0;
        exe_unit = rvv_disp_pkg::ALU;
        vs1_eew = rvv_disp_pkg::EEW8;
        vs2_eew = rvv_disp_pkg::EEW8;
        vd_eew = rvv_disp_pkg::EEW8;
        uop_index = '0;
        vm = 1'b1;
        ignore_vta = 1'b0;
        ignore_vma = 1'b0;
        out_ready = 1'b1;
        csr_we = 1'b0;
        vl_wdata = '0;
        vstart_wdata = '0;
        v0_wdata = '0;
        lfsr = 16'd27;
        stall_lfsr = 16'd27;
        stall_en = 1'b0;
        cycle = 0;
        in_flight = 0;
        held = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // unmasked EEW8 with tail
        write_cfg(40, 0, '0);
        for (int k = 0; k < 8; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW8, rvv_disp_pkg::EEW8,
                 rvv_disp_pkg::EEW8, k, 1, 0, 0);
        drain();

        // masked EEW16 and EEW32 followed by mask ignored
        rand_bits(128, rv);
        write_cfg(50, 0, rv);
        for (int k = 0; k < 8; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW16,
                 rvv_disp_pkg::EEW16, k, 0, 0, 0);
        for (int k = 0; k < 8; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW32,
                 rvv_disp_pkg::EEW32, k, 0, 0, 0);
        for (int k = 0; k < 4; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW16,
                 rvv_disp_pkg::EEW16, k, 0, 0, 1);
        send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW32,
             rvv_disp_pkg::EEW32, 3, 0, 1, 1);
        drain();

        // nonzero vstart
        rand_bits(128, rv);
        write_cfg(60, 5, rv);
        for (int k = 0; k < 4; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW8, rvv_disp_pkg::EEW8,
                 rvv_disp_pkg::EEW8, k, 0, 0, 0);
        for (int k = 0; k < 4; k++)
            send(rvv_disp_pkg::ALU, rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW32,
                 rvv_disp_pkg::EEW32, k, 1, 0, 0);
        drain();

        // widening and narrowing over every index
        rand_bits(128, rv);
        write_cfg(90, 3, rv);
        for (int a = 0; a < 3; a++)
            for (int b = 0; b < 3; b++)
                if (a != b)
                    for (int k = 0; k < 8; k++) begin
                        rand_bits(1, r);
                        send(rvv_disp_pkg::ALU, eew_of(a), eew_of(a), eew_of(b), k,
                             r[0], 0, 0);
                    end
        drain();

        // reductions
        for (int b = 0; b < 3; b++)
            for (int k = 0; k < 4; k++)
                send(rvv_disp_pkg::RDT, eew_of(b), eew_of(b), eew_of(b), k, 1, 0, 0);
        drain();

        // random traffic under output stalls
        rand_bits(128, rv);
        rand_bits(10, r);
        write_cfg(int'(r[6:0]) + 1, int'(r[9:7]), rv);
        stall_en <= 1'b1;
        for (int k = 0; k < 40; k++) begin
            rand_bits(14, r);
            send(rvv_disp_pkg::exe_unit_e'(r[0]), eew_of(int'(r[13:12])),
                 eew_of(int'(r[2:1])), eew_of(int'(r[4:3])), int'(r[7:5]), r[8], r[9],
                 r[10] & r[11]);
        end
        drain();
        stall_en <= 1'b0;
        @(posedge clk);

        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- source/rvv_dispatch_top.sv
// ------------------------------
// dispatch slice top level
// config block, pipeline and byte-type generator
// ------------------------------
`timescale 1ns/1ps

module rvv_dispatch_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  rvv_disp_pkg::exe_unit_e      exe_unit,
    input  rvv_disp_pkg::eew_e           vs1_eew,
    input  rvv_disp_pkg::eew_e           vs2_eew,
    input  rvv_disp_pkg::eew_e           vd_eew,
    input  rvv_disp_pkg::uop_index_t     uop_index,
    input  logic                         vm,
    input  logic                         ignore_vta,
    input  logic                         ignore_vma,
    output logic                         out_valid,
    input  logic                         out_ready,
    output rvv_disp_pkg::byte_type_vec_t vs2_byte_type,
    output rvv_disp_pkg::byte_type_vec_t vd_byte_type,
    output rvv_disp_pkg::byte_strobe_t   v0_strobe,
    input  logic                         csr_we,
    input  rvv_disp_pkg::vl_t            vl_wdata,
    input  rvv_disp_pkg::vstart_t        vstart_wdata,
    input  rvv_disp_pkg::v0_t            v0_wdata
);
    rvv_disp_pkg::vl_t            vl;
    rvv_disp_pkg::vstart_t        vstart;
    rvv_disp_pkg::v0_t            v0;
    rvv_disp_pkg::exe_unit_e      s1_exe_unit;
    rvv_disp_pkg::eew_e           s1_vs1_eew;
    rvv_disp_pkg::eew_e           s1_vs2_eew;
    rvv_disp_pkg::eew_e           s1_vd_eew;
    rvv_disp_pkg::uop_index_t     s1_uop_index;
    logic                         s1_vm;
    logic                         s1_ignore_vta;
    logic                         s1_ignore_vma;
    rvv_disp_pkg::byte_type_vec_t gen_vs2_byte_type;
    rvv_disp_pkg::byte_type_vec_t gen_vd_byte_type;
    rvv_disp_pkg::byte_strobe_t   gen_v0_strobe;

    dispatch_csr u_csr (
        .clk          (clk),
        .rst_n        (rst_n),
        .csr_we       (csr_we),
        .vl_wdata     (vl_wdata),
        .vstart_wdata (vstart_wdata),
        .v0_wdata     (v0_wdata),
        .vl           (vl),
        .vstart       (vstart),
        .v0           (v0)
    );

    dispatch_pipe u_pipe (
        .clk               (clk),
        .rst_n             (rst_n),
        .in_valid          (in_valid),
        .in_ready          (in_ready),
        .exe_unit          (exe_unit),
        .vs1_eew           (vs1_eew),
        .vs2_eew           (vs2_eew),
        .vd_eew            (vd_eew),
        .uop_index         (uop_index),
        .vm                (vm),
        .ignore_vta        (ignore_vta),
        .ignore_vma        (ignore_vma),
        .s1_exe_unit       (s1_exe_unit),
        .s1_vs1_eew        (s1_vs1_eew),
        .s1_vs2_eew        (s1_vs2_eew),
        .s1_vd_eew         (s1_vd_eew),
        .s1_uop_index      (s1_uop_index),
        .s1_vm             (s1_vm),
        .s1_ignore_vta     (s1_ignore_vta),
        .s1_ignore_vma     (s1_ignore_vma),
        .gen_vs2_byte_type (gen_vs2_byte_type),
        .gen_vd_byte_type  (gen_vd_byte_type),
        .gen_v0_strobe     (gen_v0_strobe),
        .out_valid         (out_valid),
        .out_ready         (out_ready),
        .vs2_byte_type     (vs2_byte_type),
        .vd_byte_type      (vd_byte_type),
        .v0_strobe         (v0_strobe)
    );

    // classifies whatever sits in stage one
    opr_byte_type u_byte_type (
        .exe_unit      (s1_exe_unit),
        .vs1_eew       (s1_vs1_eew),
        .vs2_eew       (s1_vs2_eew),
        .vd_eew        (s1_vd_eew),
        .uop_index     (s1_uop_index),
        .vm            (s1_vm),
        .ignore_vta    (s1_ignore_vta),
        .ignore_vma    (s1_ignore_vma),
        .vl            (vl),
        .vstart        (vstart),
        .v0            (v0),
        .vs2_byte_type (gen_vs2_byte_type),
        .vd_byte_type  (gen_vd_byte_type),
        .v0_strobe     (gen_v0_strobe)
    );

endmodule

//--- source/dispatch_pipe.sv
// ------------------------------
// two-stage valid/ready pipeline
// stage one holds the micro-op, stage two its byte types
// ------------------------------
`timescale 1ns/1ps

module dispatch_pipe (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    output logic                         in_ready,
    input  rvv_disp_pkg::exe_unit_e      exe_unit,
    input  rvv_disp_pkg::eew_e           vs1_eew,
    input  rvv_disp_pkg::eew_e           vs2_eew,
    input  rvv_disp_pkg::eew_e           vd_eew,
    input  rvv_disp_pkg::uop_index_t     uop_index,
    input  logic                         vm,
    input  logic                         ignore_vta,
    input  logic                         ignore_vma,
    output rvv_disp_pkg::exe_unit_e      s1_exe_unit,
    output rvv_disp_pkg::eew_e           s1_vs1_eew,
    output rvv_disp_pkg::eew_e           s1_vs2_eew,
    output rvv_disp_pkg::eew_e           s1_vd_eew,
    output rvv_disp_pkg::uop_index_t     s1_uop_index,
    output logic                         s1_vm,
    output logic                         s1_ignore_vta,
    output logic                         s1_ignore_vma,
    input  rvv_disp_pkg::byte_type_vec_t gen_vs2_byte_type,
    input  rvv_disp_pkg::byte_type_vec_t gen_vd_byte_type,
    input  rvv_disp_pkg::byte_strobe_t   gen_v0_strobe,
    output logic                         out_valid,
    input  logic                         out_ready,
    output rvv_disp_pkg::byte_type_vec_t vs2_byte_type,
    output rvv_disp_pkg::byte_type_vec_t vd_byte_type,
    output rvv_disp_pkg::byte_strobe_t   v0_strobe
);
    logic s1_valid;
    logic s2_ready;
    logic s1_adv;
    logic in_fire;

    // stage two empty or draining this edge
    assign s2_ready = !out_valid || out_ready;
    assign s1_adv   = s1_valid && s2_ready;
    assign in_ready = !s1_valid || s2_ready;
    assign in_fire  = in_valid && in_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (in_ready)
                s1_valid <= in_valid;
            if (s2_ready)
                out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_fire) begin
            s1_exe_unit   <= exe_unit;
            s1_vs1_eew    <= vs1_eew;
            s1_vs2_eew    <= vs2_eew;
            s1_vd_eew     <= vd_eew;
            s1_uop_index  <= uop_index;
            s1_vm         <= vm;
            s1_ignore_vta <= ignore_vta;
            s1_ignore_vma <= ignore_vma;
        end
        // generator output belongs to the stage-one micro-op
        if (s1_adv) begin
            vs2_byte_type <= gen_vs2_byte_type;
            vd_byte_type  <= gen_vd_byte_type;
            v0_strobe     <= gen_v0_strobe;
        end
    end

endmodule

//--- source/dispatch_csr.sv
// ------------------------------
// vl, vstart and v0 registers
// one write port loads all three at once
// ------------------------------
`timescale 1ns/1ps

module dispatch_csr (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  csr_we,
    input  rvv_disp_pkg::vl_t     vl_wdata,
    input  rvv_disp_pkg::vstart_t vstart_wdata,
    input  rvv_disp_pkg::v0_t     v0_wdata,
    output rvv_disp_pkg::vl_t     vl,
    output rvv_disp_pkg::vstart_t vstart,
    output rvv_disp_pkg::v0_t     v0
);

    // visible to stage one from the cycle after the write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vl     <= '0;
            vstart <= '0;
            v0     <= '0;
        end else if (csr_we) begin
            vl     <= vl_wdata;
            vstart <= vstart_wdata;
            v0     <= v0_wdata;
        end
    end

endmodule

//--- source/opr_byte_type.sv
// ------------------------------
// per-byte type and v0 strobe for one micro-op
// purely combinational, fed by stage one
// ------------------------------
`timescale 1ns/1ps
`include "rvv_disp_defs.svh"

module opr_byte_type (
    input  rvv_disp_pkg::exe_unit_e      exe_unit,
    input  rvv_disp_pkg::eew_e           vs1_eew,
    input  rvv_disp_pkg::eew_e           vs2_eew,
    input  rvv_disp_pkg::eew_e           vd_eew,
    input  rvv_disp_pkg::uop_index_t     uop_index,
    input  logic                         vm,
    input  logic                         ignore_vta,
    input  logic                         ignore_vma,
    input  rvv_disp_pkg::vl_t            vl,
    input  rvv_disp_pkg::vstart_t        vstart,
    input  rvv_disp_pkg::v0_t            v0,
    output rvv_disp_pkg::byte_type_vec_t vs2_byte_type,
    output rvv_disp_pkg::byte_type_vec_t vd_byte_type,
    output rvv_disp_pkg::byte_strobe_t   v0_strobe
);
    localparam int VLENB_WIDTH = $clog2(`VLENB);

    rvv_disp_pkg::eew_e    eew_max;
    logic [1:0]            eew_max_shift;
    logic [1:0]            vs2_eew_shift;
    logic [1:0]            vd_eew_shift;
    rvv_disp_pkg::vstart_t uop_vs2_start;
    rvv_disp_pkg::vstart_t uop_v0_start;
    rvv_disp_pkg::vstart_t uop_vd_start;
    rvv_disp_pkg::vl_t     uop_vd_end;
    logic [`VLENB-1:0]     vs2_enable_tmp;
    logic [`VLENB-1:0]     vd_enable_tmp;

    // widest element width among the operands
    always_comb begin
        if (vs1_eew == rvv_disp_pkg::EEW32 || vs2_eew == rvv_disp_pkg::EEW32 ||
            vd_eew == rvv_disp_pkg::EEW32) begin
            eew_max       = rvv_disp_pkg::EEW32;
            eew_max_shift = 2'd2;
        end else if (vs1_eew == rvv_disp_pkg::EEW16 || vs2_eew == rvv_disp_pkg::EEW16 ||
                     vd_eew == rvv_disp_pkg::EEW16) begin
            eew_max       = rvv_disp_pkg::EEW16;
            eew_max_shift = 2'd1;
        end else if (vs1_eew == rvv_disp_pkg::EEW8 || vs2_eew == rvv_disp_pkg::EEW8 ||
                     vd_eew == rvv_disp_pkg::EEW8) begin
            eew_max       = rvv_disp_pkg::EEW8;
            eew_max_shift = 2'd0;
        end else if (vs1_eew == rvv_disp_pkg::EEW1 || vs2_eew == rvv_disp_pkg::EEW1 ||
                     vd_eew == rvv_disp_pkg::EEW1) begin
            eew_max       = rvv_disp_pkg::EEW1;
            eew_max_shift = 2'd0;
        end else begin
            eew_max       = rvv_disp_pkg::EEW_NONE;
            eew_max_shift = 2'd0;
        end
    end

    // log2 of bytes per element
    always_comb begin
        case (vs2_eew)
            rvv_disp_pkg::EEW16: vs2_eew_shift = 2'd1;
            rvv_disp_pkg::EEW32: vs2_eew_shift = 2'd2;
            default:             vs2_eew_shift = 2'd0;
        endcase
        case (vd_eew)
            rvv_disp_pkg::EEW16: vd_eew_shift = 2'd1;
            rvv_disp_pkg::EEW32: vd_eew_shift = 2'd2;
            default:             vd_eew_shift = 2'd0;
        endcase
    end

    // first vs2 element covered by this micro-op
    always_comb begin
        if (exe_unit == rvv_disp_pkg::RDT) begin
            uop_vs2_start = rvv_disp_pkg::vstart_t'(uop_index) << (VLENB_WIDTH - vs2_eew_shift);
        end else begin
            case ({eew_max, vs2_eew})
                {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW32},
                {rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW16},
                {rvv_disp_pkg::EEW8, rvv_disp_pkg::EEW8}:
                    uop_vs2_start = rvv_disp_pkg::vstart_t'(uop_index)
                                    << (VLENB_WIDTH - vs2_eew_shift);
                // widening 2:1, two micro-ops share one vs2 register
                {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW16},
                {rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW8}:
                    uop_vs2_start = rvv_disp_pkg::vstart_t'(uop_index[`UOP_INDEX_WIDTH-1:1])
                                    << (VLENB_WIDTH - vs2_eew_shift);
                // widening 4:1
                {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW8}:
                    uop_vs2_start = rvv_disp_pkg::vstart_t'(uop_index[`UOP_INDEX_WIDTH-1:2])
                                    << (VLENB_WIDTH - vs2_eew_shift);
                default:
                    uop_vs2_start = '0;
            endcase
        end
    end

    // vd element window, narrowing writes only part of the register
    always_comb begin
        case ({eew_max, vd_eew})
            {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW32},
            {rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW16},
            {rvv_disp_pkg::EEW8, rvv_disp_pkg::EEW8}: begin
                uop_v0_start = rvv_disp_pkg::vstart_t'(uop_index) << (VLENB_WIDTH - vd_eew_shift);
                uop_vd_start = uop_v0_start;
            end
            {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW16},
            {rvv_disp_pkg::EEW16, rvv_disp_pkg::EEW8}: begin
                uop_v0_start = rvv_disp_pkg::vstart_t'(uop_index[`UOP_INDEX_WIDTH-1:1])
                               << (VLENB_WIDTH - vd_eew_shift);
                uop_vd_start = uop_v0_start + (uop_index[0] ?
                               rvv_disp_pkg::vstart_t'(`VLENB >> eew_max_shift) : '0);
            end
            {rvv_disp_pkg::EEW32, rvv_disp_pkg::EEW8}: begin
                uop_v0_start = rvv_disp_pkg::vstart_t'(uop_index[`UOP_INDEX_WIDTH-1:2])
                               << VLENB_WIDTH;
                uop_vd_start = uop_v0_start + (rvv_disp_pkg::vstart_t'(uop_index[1:0])
                               << (VLENB_WIDTH - 2));
            end
            default: begin
                // mask layout, window spans vstart to vl
                uop_v0_start = '0;
                uop_vd_start = vstart;
            end
        endcase
        if (eew_max == rvv_disp_pkg::EEW1 || eew_max == rvv_disp_pkg::EEW_NONE) begin
            uop_vd_end = vl;
        end else begin
            uop_vd_end = {1'b0, uop_vd_start}
                         + rvv_disp_pkg::vl_t'((`VLENB >> eew_max_shift) - 1);
        end
    end

    assign vs2_enable_tmp = v0[uop_vs2_start +: `VLENB];
    assign vd_enable_tmp  = v0[uop_v0_start +: `VLENB];

    always_comb begin
        rvv_disp_pkg::vl_t        ele;
        logic                     en;
        rvv_disp_pkg::byte_type_e bt;
        for (int i = 0; i < `VLENB; i++) begin
            ele = {1'b0, uop_vs2_start} + rvv_disp_pkg::vl_t'(i >> vs2_eew_shift);
            en  = vm || vs2_enable_tmp[i >> vs2_eew_shift];
            if (ignore_vta && ignore_vma)
                bt = rvv_disp_pkg::BODY_ACTIVE;
            else if (ele >= vl)
                bt = rvv_disp_pkg::TAIL;
            else if (ele < {1'b0, vstart})
                bt = rvv_disp_pkg::NOT_CHANGE;
            else if (en || ignore_vma)
                bt = rvv_disp_pkg::BODY_ACTIVE;
            else
                bt = rvv_disp_pkg::BODY_INACTIVE;
            vs2_byte_type[2*i +: 2] = bt;
        end
    end

    always_comb begin
        rvv_disp_pkg::vl_t        ele;
        logic                     en;
        logic                     strobe;
        rvv_disp_pkg::byte_type_e bt;
        for (int i = 0; i < `VLENB; i++) begin
            ele    = {1'b0, uop_v0_start} + rvv_disp_pkg::vl_t'(i >> vd_eew_shift);
            en     = vm || vd_enable_tmp[i >> vd_eew_shift];
            strobe = 1'b0;
            if (exe_unit == rvv_disp_pkg::RDT) begin
                // scalar result in element 0 only, strobe stays low
                bt = (i < (1 << vd_eew_shift)) ? rvv_disp_pkg::BODY_ACTIVE : rvv_disp_pkg::TAIL;
            end else if (ignore_vta && ignore_vma) begin
                bt = rvv_disp_pkg::BODY_ACTIVE;
            end else if (ele >= vl) begin
                bt = rvv_disp_pkg::TAIL;
            end else if (ele < {1'b0, vstart} || ele < {1'b0, uop_vd_start}) begin
                bt = rvv_disp_pkg::NOT_CHANGE;
            end else if (ele > uop_vd_end) begin
                bt = rvv_disp_pkg::BODY_INACTIVE;
            end else begin
                bt     = (en || ignore_vma) ? rvv_disp_pkg::BODY_ACTIVE
                                            : rvv_disp_pkg::BODY_INACTIVE;
                strobe = en || ignore_vma;
            end
            vd_byte_type[2*i +: 2] = bt;
            v0_strobe[i]           = strobe;
        end
    end

endmodule

//--- source/rvv_disp_pkg.sv
// ------------------------------
// shared types for the dispatch slice
// referenced by scoped name from RTL and bench
// ------------------------------
`include "rvv_disp_defs.svh"

package rvv_disp_pkg;

    // effective element width of an operand
    // five codes, so three bits are needed
    typedef enum logic [2:0] {
        EEW_NONE,
        EEW1,
        EEW8,
        EEW16,
        EEW32
    } eew_e;

    // execution unit class
    typedef enum logic {
        ALU,
        RDT
    } exe_unit_e;

    // per-byte classification
    typedef enum logic [1:0] {
        NOT_CHANGE,
        BODY_ACTIVE,
        BODY_INACTIVE,
        TAIL
    } byte_type_e;

    typedef logic [`VL_WIDTH-1:0]        vl_t;
    typedef logic [`VSTART_WIDTH-1:0]    vstart_t;
    typedef logic [`UOP_INDEX_WIDTH-1:0] uop_index_t;
    typedef logic [`VLEN-1:0]            v0_t;

    // byte 0 sits in bits [1:0]
    typedef logic [2*`VLENB-1:0]         byte_type_vec_t;
    typedef logic [`VLENB-1:0]           byte_strobe_t;

endpackage

//--- source/rvv_disp_defs.svh
// ------------------------------
// vector length macros for the dispatch slice
// include before any type or port that needs them
// ------------------------------
`ifndef RVV_DISP_DEFS_SVH
`define RVV_DISP_DEFS_SVH

// register width in bits
`define VLEN 128

// bytes per vector register
`define VLENB 16

// vl must reach VLEN itself, so one bit more than the index range
`define VL_WIDTH 8

// vstart only indexes elements below VLEN
`define VSTART_WIDTH 7

// up to eight registers per group
`define UOP_INDEX_WIDTH 3

`endif
